/* addr_decoder/addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder #(
  // Sideband width, the word for writes and the tag for reads
  parameter int width = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  valid,
  input  ram_cfg_pkg::addr_t                                    addr,
  input  logic [width-1:0]                                      data,
  output logic [ram_cfg_pkg::tiles-1:0]                         tile_valid,
  output ram_cfg_pkg::tile_addr_t [ram_cfg_pkg::tiles-1:0]      tile_addr,
  output logic [ram_cfg_pkg::tiles-1:0][width-1:0]              tile_data
);

  // ----------------------------------------------------------
  // Stage 0 splits the space in halves on address bit 5
  // ----------------------------------------------------------
  logic [1:0] s0_valid;
  logic [1:0][ram_cfg_pkg::addr_width-2:0] s0_addr;
  logic [1:0][width-1:0] s0_data;

  addr_decoder_stage #(
    .input_addr_width(ram_cfg_pkg::addr_width),
    .width(width)
  ) i_stage0 (
    .clk(clk),
    .rst(rst),
    .in_valid(valid),
    .in_addr(addr),
    .in_data(data),
    .out_valid(s0_valid),
    .out_addr(s0_addr),
    .out_data(s0_data)
  );

  // ----------------------------------------------------------
  // Stage 1 splits each half on address bit 4
  // ----------------------------------------------------------
  // Fork f of stage 0 feeds tiles 2f and 2f+1
  for (genvar f = 0; f < 2; f++) begin : gen_stage1
    addr_decoder_stage #(
      .input_addr_width(ram_cfg_pkg::addr_width - 1),
      .width(width)
    ) i_stage1 (
      .clk(clk),
      .rst(rst),
      .in_valid(s0_valid[f]),
      .in_addr(s0_addr[f]),
      .in_data(s0_data[f]),
      .out_valid(tile_valid[2*f +: 2]),
      .out_addr(tile_addr[2*f +: 2]),
      .out_data(tile_data[2*f +: 2])
    );
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  tile_valid_onehot0_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0(tile_valid));

  // Every request reaches exactly one tile after the fork stages
  latency_a: assert property (@(posedge clk) disable iff (rst)
    valid |-> ##(ram_cfg_pkg::stages) $onehot(tile_valid));

  // Tile n only sees addresses 16n to 16n+15
  for (genvar t = 0; t < ram_cfg_pkg::tiles; t++) begin : gen_tile_check
    tile_route_a: assert property (@(posedge clk) disable iff (rst)
      tile_valid[t] |->
        ($past(addr, ram_cfg_pkg::stages) >> ram_cfg_pkg::tile_addr_width) == t);
  end

endmodule

/* addr_decoder/addr_decoder_stage.sv */
`timescale 1ns/1ps

module addr_decoder_stage #(
  // Address bits seen by this stage
  parameter int input_addr_width = 6,
  // Sideband bits carried with the address
  parameter int width = 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  in_valid,
  input  logic [input_addr_width-1:0]           in_addr,
  input  logic [width-1:0]                      in_data,
  output logic [1:0]                            out_valid,
  output logic [1:0][input_addr_width-2:0]      out_addr,
  output logic [1:0][width-1:0]                 out_data
);

  // Address left over after the fork bit is consumed
  localparam int out_addr_width = input_addr_width - 1;

  // Fork select, top address bit
  logic sel;

  assign sel = in_addr[input_addr_width-1];

  // ----------------------------------------------------------
  // Valid per fork
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= '0;
    end else begin
      // At most one fork fires per request
      out_valid[0] <= in_valid && !sel;
      out_valid[1] <= in_valid && sel;
    end
  end

  // ----------------------------------------------------------
  // Address and sideband per fork
  // ----------------------------------------------------------
  for (genvar f = 0; f < 2; f++) begin : gen_fork
    // Payload only loads on the selected fork
    // Idle fork keeps its old value
    always_ff @(posedge clk) begin
      if (in_valid && (sel == 1'(f))) begin
        out_addr[f] <= in_addr[out_addr_width-1:0];
        out_data[f] <= in_data;
      end
    end
  end

endmodule

/* common/ram_cfg_pkg.sv */
package ram_cfg_pkg;

  // ----------------------------------------------------------
  // RAM geometry
  // ----------------------------------------------------------

  // Total number of words
  localparam int depth = 64;

  // Storage tiles along the depth
  localparam int tiles = 4;

  // Words held by a single tile
  localparam int tile_depth = depth / tiles;

  // Registered fork stages in each decoder
  // One stage per address bit that selects a tile
  localparam int stages = $clog2(tiles);

  // Full address and address inside one tile
  localparam int addr_width = $clog2(depth);
  localparam int tile_addr_width = $clog2(tile_depth);

  // Payload widths
  localparam int data_width = 16;
  localparam int tag_width = 4;

  // ----------------------------------------------------------
  // Width types
  // ----------------------------------------------------------
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [tile_addr_width-1:0] tile_addr_t;
  typedef logic [data_width-1:0] word_t;

  // Read tag, returned with the data
  typedef logic [tag_width-1:0] tag_t;

endpackage

/* common/ram_types_pkg.sv */
package ram_types_pkg;

  // ----------------------------------------------------------
  // Request and response bundles
  // ----------------------------------------------------------

  // Write request, address in the upper bits
  typedef struct packed {
    ram_cfg_pkg::addr_t addr;
    ram_cfg_pkg::word_t data;
  } wr_req_t;

  // Read request
  // Tag rides along through the decoder and the tile
  typedef struct packed {
    ram_cfg_pkg::addr_t addr;
    ram_cfg_pkg::tag_t tag;
  } rd_req_t;

  // Read response, tag of the matching request plus the word
  typedef struct packed {
    ram_cfg_pkg::tag_t tag;
    ram_cfg_pkg::word_t data;
  } rd_resp_t;

  // ----------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------

  // Idle issues the first zero write of a scrub
  // Scrub walks the rest of the address space
  // Ready accepts user requests
  typedef enum logic [1:0] {
    st_idle,
    st_scrub,
    st_ready
  } ctrl_state_t;

endpackage

/* source/ram_ctrl.sv */
`timescale 1ns/1ps

module ram_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clear,
  input  logic                   wr_en,
  input  ram_types_pkg::wr_req_t wr_req,
  input  logic                   rd_en,
  output logic                   ready,
  output logic                   dec_wr_en,
  output ram_types_pkg::wr_req_t dec_wr_req,
  output logic                   dec_rd_en
);

  ram_types_pkg::ctrl_state_t state;
  ram_types_pkg::ctrl_state_t state_next;

  // Scrub address counter, wraps back to zero at the end
  ram_cfg_pkg::addr_t scrub_addr;
  logic scrub_last;
  // High in idle and scrub, both issue zero writes
  logic scrubbing;

  assign scrub_last = scrub_addr == ram_cfg_pkg::addr_t'(ram_cfg_pkg::depth - 1);
  assign scrubbing = state != ram_types_pkg::st_ready;

  // ----------------------------------------------------------
  // Scrub FSM
  // ----------------------------------------------------------
  always_comb begin
    state_next = state;
    unique case (state)
      ram_types_pkg::st_idle:  state_next = ram_types_pkg::st_scrub;
      ram_types_pkg::st_scrub: if (scrub_last) state_next = ram_types_pkg::st_ready;
      // Clear only counts while ready, ignored mid scrub
      ram_types_pkg::st_ready: if (clear) state_next = ram_types_pkg::st_idle;
      default:                 state_next = ram_types_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ram_types_pkg::st_idle;
      scrub_addr <= '0;
      ready <= 1'b0;
    end else begin
      state <= state_next;
      ready <= state_next == ram_types_pkg::st_ready;
      // One word per cycle, 64 cycles from idle to ready
      if (scrubbing) begin
        scrub_addr <= scrub_addr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Request steering
  // ----------------------------------------------------------
  // Scrub owns the write decoder, user writes dropped meanwhile
  assign dec_wr_en = scrubbing || (wr_en && ready);

  always_comb begin
    if (scrubbing) begin
      dec_wr_req.addr = scrub_addr;
      dec_wr_req.data = '0;
    end else begin
      dec_wr_req = wr_req;
    end
  end

  assign dec_rd_en = rd_en && ready;

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  ready_not_in_scrub_a: assert property (@(posedge clk) disable iff (rst)
    (state == ram_types_pkg::st_scrub) |-> !ready);

endmodule

/* source/ram_tile.sv */
`timescale 1ns/1ps

module ram_tile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  ram_cfg_pkg::tile_addr_t wr_addr,
  input  ram_cfg_pkg::word_t      wr_data,
  input  logic                    rd_en,
  input  ram_cfg_pkg::tile_addr_t rd_addr,
  input  ram_cfg_pkg::tag_t       rd_tag,
  output logic                    rd_valid,
  output ram_cfg_pkg::tag_t       rd_tag_out,
  output ram_cfg_pkg::word_t      rd_data
);

  // Storage, cleared by the scrub and not by reset
  ram_cfg_pkg::word_t mem [ram_cfg_pkg::tile_depth];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ----------------------------------------------------------
  // Registered read port
  // ----------------------------------------------------------
  // Nonblocking update, so a read on the write edge sees the old word
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
      rd_tag_out <= rd_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

/* source/read_data_mux.sv */
`timescale 1ns/1ps

module read_data_mux (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [ram_cfg_pkg::tiles-1:0]                    tile_rd_valid,
  input  ram_cfg_pkg::tag_t [ram_cfg_pkg::tiles-1:0]       tile_rd_tag,
  input  ram_cfg_pkg::word_t [ram_cfg_pkg::tiles-1:0]      tile_rd_data,
  output logic                                             rd_valid,
  output ram_types_pkg::rd_resp_t                          rd_resp
);

  ram_types_pkg::rd_resp_t resp_or;

  // AND-OR select, valid is one-hot so at most one tile contributes
  always_comb begin
    resp_or = '0;
    for (int t = 0; t < ram_cfg_pkg::tiles; t++) begin
      if (tile_rd_valid[t]) begin
        resp_or.tag = resp_or.tag | tile_rd_tag[t];
        resp_or.data = resp_or.data | tile_rd_data[t];
      end
    end
  end

  // Output register, payload held between responses
  always_ff @(posedge clk) begin
    if (|tile_rd_valid) begin
      rd_resp <= resp_or;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= |tile_rd_valid;
    end
  end

  // Decoder and tile latency keep responses from colliding
  tile_rd_valid_onehot0_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0(tile_rd_valid));

endmodule

/* source/tiled_ram.sv */
`timescale 1ns/1ps

module tiled_ram (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic                     wr_en,
  input  ram_types_pkg::wr_req_t   wr_req,
  input  logic                     rd_en,
  input  ram_types_pkg::rd_req_t   rd_req,
  output logic                     ready,
  output logic                     rd_valid,
  output ram_types_pkg::rd_resp_t  rd_resp
);

  // Gated requests out of the control block
  logic dec_wr_en;
  logic dec_rd_en;
  ram_types_pkg::wr_req_t dec_wr_req;

  // Write decoder to tiles
  logic [ram_cfg_pkg::tiles-1:0] wr_tile_valid;
  ram_cfg_pkg::tile_addr_t [ram_cfg_pkg::tiles-1:0] wr_tile_addr;
  ram_cfg_pkg::word_t [ram_cfg_pkg::tiles-1:0] wr_tile_data;

  // Read decoder to tiles, tag as sideband
  logic [ram_cfg_pkg::tiles-1:0] rd_tile_valid;
  ram_cfg_pkg::tile_addr_t [ram_cfg_pkg::tiles-1:0] rd_tile_addr;
  ram_cfg_pkg::tag_t [ram_cfg_pkg::tiles-1:0] rd_tile_tag;

  // Tiles to read mux
  logic [ram_cfg_pkg::tiles-1:0] tile_rd_valid;
  ram_cfg_pkg::tag_t [ram_cfg_pkg::tiles-1:0] tile_rd_tag;
  ram_cfg_pkg::word_t [ram_cfg_pkg::tiles-1:0] tile_rd_data;

  // ----------------------------------------------------------
  // Scrub and request gating
  // ----------------------------------------------------------
  ram_ctrl i_ctrl (
    .clk(clk),
    .rst(rst),
    .clear(clear),
    .wr_en(wr_en),
    .wr_req(wr_req),
    .rd_en(rd_en),
    .ready(ready),
    .dec_wr_en(dec_wr_en),
    .dec_wr_req(dec_wr_req),
    .dec_rd_en(dec_rd_en)
  );

  // ----------------------------------------------------------
  // Address decoders
  // ----------------------------------------------------------
  addr_decoder #(
    .width(ram_cfg_pkg::data_width)
  ) i_wr_dec (
    .clk(clk),
    .rst(rst),
    .valid(dec_wr_en),
    .addr(dec_wr_req.addr),
    .data(dec_wr_req.data),
    .tile_valid(wr_tile_valid),
    .tile_addr(wr_tile_addr),
    .tile_data(wr_tile_data)
  );

  addr_decoder #(
    .width(ram_cfg_pkg::tag_width)
  ) i_rd_dec (
    .clk(clk),
    .rst(rst),
    .valid(dec_rd_en),
    .addr(rd_req.addr),
    .data(rd_req.tag),
    .tile_valid(rd_tile_valid),
    .tile_addr(rd_tile_addr),
    .tile_data(rd_tile_tag)
  );

  // ----------------------------------------------------------
  // Storage tiles and response mux
  // ----------------------------------------------------------
  for (genvar t = 0; t < ram_cfg_pkg::tiles; t++) begin : gen_tile
    ram_tile i_tile (
      .clk(clk),
      .rst(rst),
      .wr_en(wr_tile_valid[t]),
      .wr_addr(wr_tile_addr[t]),
      .wr_data(wr_tile_data[t]),
      .rd_en(rd_tile_valid[t]),
      .rd_addr(rd_tile_addr[t]),
      .rd_tag(rd_tile_tag[t]),
      .rd_valid(tile_rd_valid[t]),
      .rd_tag_out(tile_rd_tag[t]),
      .rd_data(tile_rd_data[t])
    );
  end

  read_data_mux i_rd_mux (
    .clk(clk),
    .rst(rst),
    .tile_rd_valid(tile_rd_valid),
    .tile_rd_tag(tile_rd_tag),
    .tile_rd_data(tile_rd_data),
    .rd_valid(rd_valid),
    .rd_resp(rd_resp)
  );

endmodule

/* tb.f */
common/ram_cfg_pkg.sv
common/ram_types_pkg.sv
addr_decoder/addr_decoder_stage.sv
addr_decoder/addr_decoder.sv
source/ram_ctrl.sv
source/ram_tile.sv
source/read_data_mux.sv
source/tiled_ram.sv
test/tb_clock_gen.sv
test/tb_tiled_ram.sv

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  // Clock period in ns
  parameter real period = 8.0
) (
  output logic clk
);

  // Free running, starts low
  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule

/* test/tb_tiled_ram.sv */
`timescale 1ns/1ps

module tb_tiled_ram;

  // Edges from an accepted read strobe to rd_valid
  localparam int rd_latency = 4;

  typedef enum logic [2:0] {op_nop, op_write, op_read, op_wr_rd, op_wait} op_t;

  // One table row, applied in one cycle
  typedef struct packed {
    op_t op;
    ram_cfg_pkg::addr_t addr;
    ram_cfg_pkg::word_t data;
    ram_cfg_pkg::tag_t tag;
    logic clear;
  } entry_t;

  // Expected response and the cycle it is due in
  typedef struct packed {
    int unsigned due;
    ram_types_pkg::rd_resp_t resp;
  } exp_resp_t;

  logic clk;
  logic rst;
  logic clear;
  logic wr_en;
  ram_types_pkg::wr_req_t wr_req;
  logic rd_en;
  ram_types_pkg::rd_req_t rd_req;
  logic ready;
  logic rd_valid;
  ram_types_pkg::rd_resp_t rd_resp;

  entry_t table_q[$];
  exp_resp_t exp_q[$];
  // Reference model of the memory
  ram_cfg_pkg::word_t mem_m [ram_cfg_pkg::depth];
  integer seed = 32'he8ec7a73;
  ram_cfg_pkg::tag_t next_tag = '0;
  int unsigned cyc = 0;
  // Edges left until ready rises again
  int busy = ram_cfg_pkg::depth;
  logic ready_m = 1'b0;

  tb_clock_gen #(.period(8.0)) i_clk (.clk(clk));

  tiled_ram i_dut (
    .clk(clk),
    .rst(rst),
    .clear(clear),
    .wr_en(wr_en),
    .wr_req(wr_req),
    .rd_en(rd_en),
    .rd_req(rd_req),
    .ready(ready),
    .rd_valid(rd_valid),
    .rd_resp(rd_resp)
  );

  // ----------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    abort_run();
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  function automatic ram_cfg_pkg::word_t rand_word();
    return ram_cfg_pkg::word_t'($random(seed));
  endfunction

  // Reads take a fresh tag each, so reordering would show
  task automatic add_entry(input op_t op, input int addr, input ram_cfg_pkg::word_t data,
                           input logic clr);
    entry_t e;
    e.op = op;
    e.addr = ram_cfg_pkg::addr_t'(addr);
    e.data = data;
    e.tag = next_tag;
    e.clear = clr;
    if (op == op_read || op == op_wr_rd) begin
      next_tag = next_tag + 1'b1;
    end
    table_q.push_back(e);
  endtask

  task automatic read_all_words();
    for (int a = 0; a < ram_cfg_pkg::depth; a++) begin
      add_entry(op_read, a, '0, 1'b0);
    end
  endtask

  task automatic build_table();
    // Strobes during the first scrub, all dropped
    // Addresses the scrub already passed, so a leaked write would stay
    add_entry(op_write, 0, 16'hdead, 1'b0);
    add_entry(op_read, 0, '0, 1'b0);
    add_entry(op_wr_rd, 1, 16'hbeef, 1'b0);
    add_entry(op_wait, 0, '0, 1'b0);
    read_all_words();
    // Write then read, then back to back reads
    add_entry(op_write, 10, rand_word(), 1'b0);
    add_entry(op_read, 10, '0, 1'b0);
    add_entry(op_read, 30, '0, 1'b0);
    add_entry(op_read, 10, '0, 1'b0);
    add_entry(op_read, 40, '0, 1'b0);
    add_entry(op_read, 63, '0, 1'b0);
    // Lowest, middle and highest word of each tile
    for (int t = 0; t < ram_cfg_pkg::tiles; t++) begin
      add_entry(op_write, t * ram_cfg_pkg::tile_depth, rand_word(), 1'b0);
      add_entry(op_write, t * ram_cfg_pkg::tile_depth + 8, rand_word(), 1'b0);
      add_entry(op_write, t * ram_cfg_pkg::tile_depth + 15, rand_word(), 1'b0);
    end
    read_all_words();
    // Same cycle read sees the old word, next cycle the new one
    add_entry(op_wr_rd, 20, rand_word(), 1'b0);
    add_entry(op_read, 20, '0, 1'b0);
    add_entry(op_nop, 0, '0, 1'b1);
    // Word 0 is the first one the new scrub clears
    add_entry(op_write, 0, rand_word(), 1'b0);
    add_entry(op_read, 0, '0, 1'b0);
    add_entry(op_wait, 0, '0, 1'b0);
    read_all_words();
  endtask

  // ----------------------------------------------------------
  // Driving and reference model
  // ----------------------------------------------------------
  // Advance one edge and track the expected ready level
  task automatic step();
    @(posedge clk);
    cyc = cyc + 1;
    if (!rst && busy > 0) begin
      busy = busy - 1;
    end
    ready_m = !rst && (busy == 0);
  endtask

  task automatic drive_idle();
    wr_en <= 1'b0;
    rd_en <= 1'b0;
    clear <= 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    logic do_rd;
    logic do_wr;
    exp_resp_t r;
    do_rd = (e.op == op_read) || (e.op == op_wr_rd);
    do_wr = (e.op == op_write) || (e.op == op_wr_rd);
    wr_en <= do_wr;
    wr_req.addr <= e.addr;
    wr_req.data <= e.data;
    rd_en <= do_rd;
    rd_req.addr <= e.addr;
    rd_req.tag <= e.tag;
    clear <= e.clear;
    // Only strobes seen with ready high reach the memory
    if (ready_m) begin
      if (do_rd) begin
        r.due = cyc + rd_latency;
        r.resp.tag = e.tag;
        r.resp.data = mem_m[e.addr];
        exp_q.push_back(r);
      end
      if (do_wr) begin
        mem_m[e.addr] = e.data;
      end
      if (e.clear) begin
        foreach (mem_m[a]) mem_m[a] = '0;
        // Scrub starts on the edge that takes the clear
        busy = ram_cfg_pkg::depth + 1;
      end
    end
  endtask

  // ----------------------------------------------------------
  // Output checks, sampled mid cycle
  // ----------------------------------------------------------
  always @(negedge clk) begin : check_outputs
    exp_resp_t r;
    if (cyc > 0) begin
      assert (ready === ready_m) else report_mismatch("ready", ready, ready_m);
      assert (!$isunknown(rd_valid)) else report_error("rd_valid is unknown");
      if (rd_valid) begin
        assert (exp_q.size() > 0) else report_error("rd_valid with no read outstanding");
        r = exp_q.pop_front();
        assert (r.due == cyc) else report_mismatch("rd_valid cycle", cyc, r.due);
        assert (rd_resp.tag === r.resp.tag)
          else report_mismatch("rd_resp.tag", rd_resp.tag, r.resp.tag);
        assert (rd_resp.data === r.resp.data)
          else report_mismatch("rd_resp.data", rd_resp.data, r.resp.data);
      end else if (exp_q.size() > 0) begin
        assert (exp_q[0].due > cyc) else report_error("read response missing at its cycle");
      end
    end
  end

  // Budget of ten cycles per row plus margin and one scrub
  initial begin : watchdog
    int limit;
    #1;
    limit = table_q.size() * 10 + 200 + ram_cfg_pkg::depth;
    repeat (limit) @(posedge clk);
    report_error("watchdog timeout, the run did not finish in time");
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst = 1'b1;
    clear = 1'b0;
    wr_en = 1'b0;
    rd_en = 1'b0;
    wr_req = '0;
    rd_req = '0;
    foreach (mem_m[a]) mem_m[a] = '0;
    build_table();
    repeat (16) step();
    rst <= 1'b0;
    foreach (table_q[i]) begin
      if (table_q[i].op == op_wait) begin
        while (!ready_m) begin
          step();
          drive_idle();
        end
      end else begin
        step();
        apply_entry(table_q[i]);
      end
    end
    step();
    drive_idle();
    // Drain, then a few quiet cycles for stray responses
    while (exp_q.size() > 0) step();
    repeat (8) step();
    $display("Everything OK");
    $finish;
  end

endmodule
